// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f arm_exec.f --top-module exec_tb -o exec_sim
	./obj_dir/exec_sim > sim.log 2>&1 || true
	cat sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

// File: arm_exec.f
logic/arm_exec_pkg.sv
logic/data_proc_alu.sv
logic/booth2_multiplier.sv
logic/exec_result_merge.sv
logic/exec_stage.sv
test/tb_clock.sv
test/exec_assert.sv
test/exec_tb.sv

// File: logic/arm_exec_pkg.sv
package arm_exec_pkg;

	// data-processing opcodes, taken from insn[24:21]
	localparam logic [3:0] alu_and = 4'h0;
	localparam logic [3:0] alu_eor = 4'h1;
	localparam logic [3:0] alu_sub = 4'h2;
	localparam logic [3:0] alu_rsb = 4'h3;
	localparam logic [3:0] alu_add = 4'h4;
	localparam logic [3:0] alu_adc = 4'h5;
	localparam logic [3:0] alu_sbc = 4'h6;
	localparam logic [3:0] alu_rsc = 4'h7;
	localparam logic [3:0] alu_tst = 4'h8;	// flags only
	localparam logic [3:0] alu_teq = 4'h9;	// flags only
	localparam logic [3:0] alu_cmp = 4'ha;	// flags only
	localparam logic [3:0] alu_cmn = 4'hb;	// flags only
	localparam logic [3:0] alu_orr = 4'hc;
	localparam logic [3:0] alu_mov = 4'hd;
	localparam logic [3:0] alu_bic = 4'he;
	localparam logic [3:0] alu_mvn = 4'hf;

	// status word flag positions
	localparam int cpsr_n = 31;
	localparam int cpsr_z = 30;
	localparam int cpsr_c = 29;
	localparam int cpsr_v = 28;

	// MUL/MLA: bits 27:22 zero, bits 7:4 = 1001
	localparam logic [31:0] mult_mask  = 32'h0fc0_00f0;
	localparam logic [31:0] mult_match = 32'h0000_0090;

	// data processing: bits 27:26 zero
	// the multiply pattern also matches this one, so it has to be tested first
	localparam logic [31:0] dp_mask  = 32'h0c00_0000;
	localparam logic [31:0] dp_match = 32'h0000_0000;

	// instruction fields
	localparam int insn_s_bit = 20;	// set flags
	localparam int insn_a_bit = 21;	// accumulate, multiply only
	localparam int rd_lsb     = 12;	// Rd of a data-processing op
	localparam int mul_rd_lsb = 16;	// Rd of a multiply

endpackage

// File: logic/booth2_multiplier.sv
`timescale 1ns/1ns

module booth2_multiplier (
	input  logic        clk,
	input  logic        rst,
	input  logic        start,
	input  logic [31:0] acc0,
	input  logic [31:0] in0,
	input  logic [31:0] in1,
	output logic        done,
	output logic [31:0] result
);

	logic        busy;
	logic [31:0] bitfield;	// multiplier bits not yet retired
	logic [31:0] mcand;	// multiplicand, moves left with bitfield
	logic [31:0] acc;
	logic [31:0] partial;

	// two multiplier bits pick 0, 1, 2 or 3 times the multiplicand
	assign partial = (bitfield[0] ? mcand : 32'd0)
		+ (bitfield[1] ? {mcand[30:0], 1'b0} : 32'd0);

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (!busy) begin
				if (start)
					busy <= 1'b1;
			end else if (bitfield == 32'd0) begin
				busy <= 1'b0;	// nothing left to add
				done <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start && !busy) begin
			bitfield <= in0;
			mcand <= in1;
			acc <= acc0;
		end else if (busy) begin
			bitfield <= {2'b00, bitfield[31:2]};
			mcand <= {mcand[29:0], 2'b00};
			acc <= acc + partial;
			if (bitfield == 32'd0)
				result <= acc;
		end
	end

endmodule

// File: logic/data_proc_alu.sv
`timescale 1ns/1ns

module data_proc_alu (
	input  logic [31:0] in0,
	input  logic [31:0] in1,
	input  logic [31:0] cpsr,
	input  logic [3:0]  op,
	input  logic        setflags,
	input  logic        shifter_carry,
	output logic [31:0] result,
	output logic [31:0] cpsr_out,
	output logic        setres
);

	logic [31:0] add_a;
	logic [31:0] add_b;
	logic        add_cin;
	logic [32:0] add_sum;
	logic        arith;	// op goes through the adder
	logic        flag_n;
	logic        flag_z;
	logic        flag_c;
	logic        flag_v;

	// one adder for every arithmetic op, subtraction is a + ~b + 1
	always_comb begin
		add_a = in0;
		add_b = in1;
		add_cin = 1'b0;
		case (op)
			arm_exec_pkg::alu_sub,
			arm_exec_pkg::alu_cmp: begin
				add_b = ~in1;
				add_cin = 1'b1;
			end
			arm_exec_pkg::alu_rsb: begin
				add_a = in1;
				add_b = ~in0;
				add_cin = 1'b1;
			end
			arm_exec_pkg::alu_adc: begin
				add_cin = cpsr[arm_exec_pkg::cpsr_c];
			end
			arm_exec_pkg::alu_sbc: begin
				add_b = ~in1;
				add_cin = cpsr[arm_exec_pkg::cpsr_c];	// borrow is !C
			end
			arm_exec_pkg::alu_rsc: begin
				add_a = in1;
				add_b = ~in0;
				add_cin = cpsr[arm_exec_pkg::cpsr_c];
			end
			default: begin
				add_cin = 1'b0;	// add, cmn, logical ops
			end
		endcase
	end

	assign add_sum = {1'b0, add_a} + {1'b0, add_b} + {32'd0, add_cin};

	always_comb begin
		result = add_sum[31:0];
		arith = 1'b1;
		setres = 1'b1;
		case (op)
			arm_exec_pkg::alu_and,
			arm_exec_pkg::alu_tst: begin
				result = in0 & in1;
				arith = 1'b0;
			end
			arm_exec_pkg::alu_eor,
			arm_exec_pkg::alu_teq: begin
				result = in0 ^ in1;
				arith = 1'b0;
			end
			arm_exec_pkg::alu_orr: begin
				result = in0 | in1;
				arith = 1'b0;
			end
			arm_exec_pkg::alu_mov: begin
				result = in1;
				arith = 1'b0;
			end
			arm_exec_pkg::alu_bic: begin
				result = in0 & ~in1;
				arith = 1'b0;
			end
			arm_exec_pkg::alu_mvn: begin
				result = ~in1;
				arith = 1'b0;
			end
			default: begin
				arith = 1'b1;
			end
		endcase
		// compare and test ops only touch the flags
		if (op[3:2] == 2'b10)
			setres = 1'b0;
	end

	assign flag_n = result[31];
	assign flag_z = (result == 32'd0);
	assign flag_c = arith ? add_sum[32] : shifter_carry;	// carry out, i.e. not borrow
	// overflow on the addition actually performed
	assign flag_v = arith ? ((add_a[31] == add_b[31]) && (add_sum[31] != add_a[31]))
		: cpsr[arm_exec_pkg::cpsr_v];

	always_comb begin
		cpsr_out = cpsr;
		if (setflags) begin
			cpsr_out[arm_exec_pkg::cpsr_n] = flag_n;
			cpsr_out[arm_exec_pkg::cpsr_z] = flag_z;
			cpsr_out[arm_exec_pkg::cpsr_c] = flag_c;
			cpsr_out[arm_exec_pkg::cpsr_v] = flag_v;
		end
	end

endmodule

// File: logic/exec_result_merge.sv
`timescale 1ns/1ns

module exec_result_merge (
	input  logic        clk,
	input  logic        rst,
	input  logic        stall,
	input  logic        inbubble,
	input  logic [31:0] insn,
	input  logic [31:0] cpsr,
	input  logic [31:0] op0,
	input  logic [31:0] op1,
	input  logic [31:0] op2,
	input  logic [31:0] alu_result,
	input  logic [31:0] alu_cpsr,
	input  logic        alu_setres,
	input  logic        mult_done,
	input  logic [31:0] mult_result,
	output logic        mult_start,
	output logic [31:0] mult_in0,
	output logic [31:0] mult_in1,
	output logic [31:0] mult_acc0,
	output logic        outstall,
	output logic        outbubble,
	output logic        write_reg,
	output logic [31:0] outcpsr,
	output logic [31:0] write_data,
	output logic [3:0]  write_num
);

	typedef enum logic [1:0] {
		st_idle,
		st_wait,	// product being computed
		st_hold	// product ready, external stall still high
	} state_t;

	state_t      state;
	state_t      state_next;
	logic        is_mult;
	logic        is_dp;
	logic        deliver;	// product goes to the write port this cycle
	logic [31:0] mult_held;
	logic [31:0] product;
	logic        next_outbubble;
	logic        next_write_reg;
	logic [31:0] next_outcpsr;
	logic [31:0] next_write_data;
	logic [3:0]  next_write_num;

	// multiply is checked first, it is a special case of the dp pattern
	assign is_mult = !inbubble
		&& ((insn & arm_exec_pkg::mult_mask) == arm_exec_pkg::mult_match);
	assign is_dp = !inbubble && !is_mult
		&& ((insn & arm_exec_pkg::dp_mask) == arm_exec_pkg::dp_match);

	assign mult_start = (state == st_idle) && is_mult;
	assign mult_in0 = op0;	// Rm
	assign mult_in1 = op1;	// Rs
	assign mult_acc0 = insn[arm_exec_pkg::insn_a_bit] ? op2 : 32'd0;

	assign deliver = ((state == st_wait) && mult_done) || (state == st_hold);
	assign product = (state == st_hold) ? mult_held : mult_result;
	// upstream holds the multiply until its product is taken
	assign outstall = (mult_start || (state != st_idle)) && !(deliver && !stall);

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (is_mult)
					state_next = st_wait;
			end
			st_wait: begin
				if (mult_done)
					state_next = stall ? st_hold : st_idle;
			end
			st_hold: begin
				if (!stall)
					state_next = st_idle;
			end
			default: begin
				state_next = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= st_idle;
		else
			state <= state_next;
	end

	always_ff @(posedge clk) begin
		if (mult_done)
			mult_held <= mult_result;	// kept for the stall case
	end

	always_comb begin
		next_outbubble = inbubble;
		next_outcpsr = cpsr;
		next_write_reg = 1'b0;
		next_write_num = 4'd0;
		next_write_data = 32'd0;
		if (deliver) begin
			next_outbubble = 1'b0;
			next_write_reg = 1'b1;
			next_write_num = insn[arm_exec_pkg::mul_rd_lsb +: 4];
			next_write_data = product;
		end else if (is_mult) begin
			next_outbubble = 1'b1;	// no product yet
		end else if (is_dp) begin
			next_outcpsr = alu_cpsr;
			if (alu_setres) begin
				next_write_reg = 1'b1;
				next_write_num = insn[arm_exec_pkg::rd_lsb +: 4];
				next_write_data = alu_result;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			outbubble <= 1'b1;
			outcpsr <= 32'd0;
			write_reg <= 1'b0;
			write_num <= 4'd0;
			write_data <= 32'd0;
		end else if (!stall) begin
			outbubble <= next_outbubble;
			outcpsr <= next_outcpsr;
			write_reg <= next_write_reg;
			write_num <= next_write_num;
			write_data <= next_write_data;
		end
	end

endmodule

// File: logic/exec_stage.sv
`timescale 1ns/1ns

module exec_stage (
	input  logic        clk,
	input  logic        rst,
	input  logic        stall,
	input  logic        inbubble,
	input  logic [31:0] insn,
	input  logic [31:0] cpsr,
	input  logic [31:0] op0,
	input  logic [31:0] op1,
	input  logic [31:0] op2,
	input  logic        carry,
	output logic        outstall,
	output logic        outbubble,
	output logic [31:0] outcpsr,
	output logic        write_reg,
	output logic [3:0]  write_num,
	output logic [31:0] write_data
);

	logic [31:0] alu_result;
	logic [31:0] alu_cpsr;
	logic        alu_setres;
	logic        mult_start;
	logic [31:0] mult_in0;
	logic [31:0] mult_in1;
	logic [31:0] mult_acc0;
	logic        mult_done;
	logic [31:0] mult_result;

	data_proc_alu alu0 (
		.in0(op0),
		.in1(op1),
		.cpsr(cpsr),
		.op(insn[24:21]),
		.setflags(insn[arm_exec_pkg::insn_s_bit]),
		.shifter_carry(carry),
		.result(alu_result),
		.cpsr_out(alu_cpsr),
		.setres(alu_setres)
	);

	booth2_multiplier mul0 (
		.clk(clk),
		.rst(rst),
		.start(mult_start),
		.acc0(mult_acc0),
		.in0(mult_in0),
		.in1(mult_in1),
		.done(mult_done),
		.result(mult_result)
	);

	exec_result_merge merge0 (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.inbubble(inbubble),
		.insn(insn),
		.cpsr(cpsr),
		.op0(op0),
		.op1(op1),
		.op2(op2),
		.alu_result(alu_result),
		.alu_cpsr(alu_cpsr),
		.alu_setres(alu_setres),
		.mult_done(mult_done),
		.mult_result(mult_result),
		.mult_start(mult_start),
		.mult_in0(mult_in0),
		.mult_in1(mult_in1),
		.mult_acc0(mult_acc0),
		.outstall(outstall),
		.outbubble(outbubble),
		.write_reg(write_reg),
		.outcpsr(outcpsr),
		.write_data(write_data),
		.write_num(write_num)
	);

endmodule

// File: test/exec_assert.sv
`timescale 1ns/1ns

module exec_assert (
	input logic clk,
	input logic rst,
	input logic mult_start,
	input logic mult_done,
	input logic outstall,
	input logic outbubble,
	input logic write_reg
);

	logic       pending;	// a multiply has started and not finished
	logic [5:0] stall_run;	// consecutive cycles with outstall high

	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= 1'b0;
			stall_run <= 6'd0;
		end else begin
			if (mult_start)
				pending <= 1'b1;
			else if (mult_done)
				pending <= 1'b0;
			stall_run <= outstall ? stall_run + 6'd1 : 6'd0;
		end
	end

	a_one_multiply: assert property (@(posedge clk) disable iff (rst)
		mult_start |-> !pending)
		else $error("multiplier started while a multiply was still pending");

	a_stall_ends: assert property (@(posedge clk) disable iff (rst)
		stall_run <= 6'd20)
		else $error("outstall stayed high for more than 20 cycles");

	a_bubble_no_write: assert property (@(posedge clk) disable iff (rst)
		outbubble |-> !write_reg)
		else $error("register write requested on a bubble");

endmodule

bind exec_result_merge exec_assert chk0 (
	.clk(clk),
	.rst(rst),
	.mult_start(mult_start),
	.mult_done(mult_done),
	.outstall(outstall),
	.outbubble(outbubble),
	.write_reg(write_reg)
);

// File: test/exec_stim.txt
// stall inbubble insn cpsr op0 op1 op2 carry | expected: outbubble write_reg write_num
// write_data outcpsr (all hex); first word is the number of vectors
1C
0 0 E0012000 00000000 F0F0F0F0 FF00FF00 00000000 0  0 1 2 F000F000 00000000
0 0 E0313000 10000000 F0F0F0F0 FF00FF00 00000000 1  0 1 3 0FF00FF0 30000000
0 0 E0514000 00000000 00000005 00000007 00000000 0  0 1 4 FFFFFFFE 80000000
0 0 E0715000 00000000 00000001 80000000 00000000 0  0 1 5 7FFFFFFF 30000000
// add overflow, carry out and zero, low status bits kept
0 0 E0916000 00000000 7FFFFFFF 00000001 00000000 0  0 1 6 80000000 90000000
0 0 E0917000 00000000 FFFFFFFF 00000001 00000000 0  0 1 7 00000000 60000000
0 0 E0916000 000000D3 00000002 00000003 00000000 0  0 1 6 00000005 000000D3
// adc, sbc, rsc with carry in
0 0 E0B18000 20000000 00000010 00000020 00000000 0  0 1 8 00000031 00000000
0 0 E0D19000 00000000 00000010 00000005 00000000 0  0 1 9 0000000A 20000000
0 0 E0F1A000 20000000 00000003 00000003 00000000 0  0 1 A 00000000 60000000
// tst teq cmp cmn write no register
0 0 E111B000 10000000 000000F0 0000000F 00000000 0  0 0 0 00000000 50000000
0 0 E131C000 00000000 80000000 00000000 00000000 1  0 0 0 00000000 A0000000
0 0 E151D000 00000000 00000003 00000005 00000000 0  0 0 0 00000000 80000000
0 0 E151E000 00000000 80000000 00000001 00000000 0  0 0 0 00000000 30000000
0 0 E171F000 00000000 FFFFFFFF 00000001 00000000 0  0 0 0 00000000 60000000
0 0 E1812000 F0000000 00FF0000 0000FF00 00000000 0  0 1 2 00FFFF00 F0000000
0 0 E1B03000 70000000 12345678 80000000 00000000 0  0 1 3 80000000 90000000
0 0 E1C14000 00000000 FFFFFFFF 0000FFFF 00000000 0  0 1 4 FFFF0000 00000000
0 0 E1F05000 00000000 00000000 00000000 00000000 1  0 1 5 FFFFFFFF A0000000
// external stall holds the outputs
1 0 E0912000 00000000 00000001 00000001 00000000 0  0 1 5 FFFFFFFF A0000000
1 0 E0912000 00000000 00000001 00000001 00000000 0  0 1 5 FFFFFFFF A0000000
0 0 E0912000 00000000 00000001 00000001 00000000 0  0 1 2 00000002 00000000
// bubbles and other instruction classes
0 1 E0012000 40000000 00000001 00000001 00000000 0  1 0 0 00000000 40000000
0 0 EA000010 20000000 00000001 00000001 00000000 0  0 0 0 00000000 20000000
0 0 E5912000 80000000 00000001 00000001 00000000 0  0 0 0 00000000 80000000
0 1 E0030291 00000000 00000007 00000003 00000000 0  1 0 0 00000000 00000000
1 0 E0912000 00000000 00000004 00000004 00000000 0  1 0 0 00000000 00000000
0 0 E0418000 C0000000 00000009 00000004 00000000 0  0 1 8 00000005 C0000000

// File: test/exec_tb.sv
`timescale 1ns/1ns

module exec_tb;

	localparam int fields = 13;	// words per stimulus vector
	localparam int max_vec = 64;
	localparam int rand_mults = 24;

	logic        clk;
	logic        rst;
	logic        stall;
	logic        inbubble;
	logic [31:0] insn;
	logic [31:0] cpsr;
	logic [31:0] op0;
	logic [31:0] op1;
	logic [31:0] op2;
	logic        carry;
	logic        outstall;
	logic        outbubble;
	logic [31:0] outcpsr;
	logic        write_reg;
	logic [3:0]  write_num;
	logic [31:0] write_data;

	logic [31:0] stim_mem [0:fields*max_vec];
	int          nvec;
	int          cycles = 0;
	int          limit = 100000;	// replaced once the file is read

	tb_clock clk0 (.clk(clk));

	exec_stage dut0 (
		.clk(clk),
		.rst(rst),
		.stall(stall),
		.inbubble(inbubble),
		.insn(insn),
		.cpsr(cpsr),
		.op0(op0),
		.op1(op1),
		.op2(op2),
		.carry(carry),
		.outstall(outstall),
		.outbubble(outbubble),
		.outcpsr(outcpsr),
		.write_reg(write_reg),
		.write_num(write_num),
		.write_data(write_data)
	);

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > limit) begin
			$display("timeout: the run did not finish within %0d cycles", limit);
			$display("** FAIL **");
			$fatal(1, "simulation hung");
		end
	end

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED %s: got %h expected %h", name, actual, expected);
			$display("** FAIL **");
			$fatal(1, "output mismatch");
		end
	endtask

	// called 10 ns after a rising edge
	task automatic drive(input logic s, input logic b, input logic [31:0] i,
		input logic [31:0] c, input logic [31:0] a0, input logic [31:0] a1,
		input logic [31:0] a2, input logic cy);
		stall = s;
		inbubble = b;
		insn = i;
		cpsr = c;
		op0 = a0;
		op1 = a1;
		op2 = a2;
		carry = cy;
	endtask

	task automatic run_vector(input int idx);
		int base;
		base = 1 + idx * fields;
		#9;
		drive(stim_mem[base][0], stim_mem[base+1][0], stim_mem[base+2], stim_mem[base+3],
			stim_mem[base+4], stim_mem[base+5], stim_mem[base+6], stim_mem[base+7][0]);
		@(posedge clk);
		#1;
		check_value("outbubble", 32'(outbubble), stim_mem[base+8]);
		check_value("write_reg", 32'(write_reg), stim_mem[base+9]);
		check_value("write_num", 32'(write_num), stim_mem[base+10]);
		check_value("write_data", write_data, stim_mem[base+11]);
		check_value("outcpsr", outcpsr, stim_mem[base+12]);
	endtask

	// MUL/MLA word with Rd in 19:16
	function automatic logic [31:0] mult_insn(input logic acc, input logic [3:0] rd,
		input logic [3:0] rs, input logic [3:0] rm);
		logic [31:0] w;
		w = 32'he000_0000 | arm_exec_pkg::mult_match;
		w[arm_exec_pkg::insn_a_bit] = acc;
		w[arm_exec_pkg::mul_rd_lsb +: 4] = rd;
		w[11:8] = rs;
		w[3:0] = rm;
		return w;
	endfunction

	task automatic check_product(input logic [31:0] i, input logic [31:0] c,
		input logic [31:0] expected);
		check_value("outbubble", 32'(outbubble), 32'd0);
		check_value("write_reg", 32'(write_reg), 32'd1);
		check_value("write_num", 32'(write_num), 32'(i[arm_exec_pkg::mul_rd_lsb +: 4]));
		check_value("write_data", write_data, expected);
		check_value("outcpsr", outcpsr, c);
	endtask

	task automatic run_multiply(input logic [31:0] i, input logic [31:0] c,
		input logic [31:0] a0, input logic [31:0] a1, input logic [31:0] a2);
		logic [31:0] expected;
		expected = a0 * a1 + (i[arm_exec_pkg::insn_a_bit] ? a2 : 32'd0);
		#9;
		drive(1'b0, 1'b0, i, c, a0, a1, a2, 1'b0);
		@(negedge clk);
		check_value("outstall", 32'(outstall), 32'd1);
		while (outstall)
			@(negedge clk);
		@(posedge clk);
		#1;
		check_product(i, c, expected);
	endtask

	// product finishes while the later stages hold the pipeline
	task automatic multiply_under_stall(input logic [31:0] i, input logic [31:0] a0,
		input logic [31:0] a1, input logic [31:0] a2);
		logic [31:0] expected;
		expected = a0 * a1 + (i[arm_exec_pkg::insn_a_bit] ? a2 : 32'd0);
		#9;
		drive(1'b0, 1'b0, i, 32'h4000_0000, a0, a1, a2, 1'b0);
		@(posedge clk);
		#1;
		check_value("outbubble", 32'(outbubble), 32'd1);
		#9;
		stall = 1'b1;
		repeat (10) begin
			@(posedge clk);
			#1;
			check_value("outbubble", 32'(outbubble), 32'd1);	// held
			check_value("write_reg", 32'(write_reg), 32'd0);
			check_value("write_data", write_data, 32'd0);
			check_value("outstall", 32'(outstall), 32'd1);
		end
		#9;
		stall = 1'b0;
		@(negedge clk);
		while (outstall)
			@(negedge clk);
		@(posedge clk);
		#1;
		check_product(i, 32'h4000_0000, expected);
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] seed_ret;
		seed_ret = $urandom(32'ha7f2301c);
		rst = 1'b1;
		drive(1'b0, 1'b1, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 1'b0);
		$readmemh("test/exec_stim.txt", stim_mem);
		nvec = int'(stim_mem[0]);
		if (nvec < 1 || nvec > max_vec) begin
			$display("stimulus file holds a bad vector count %0d", nvec);
			$display("** FAIL **");
			$fatal(1, "bad stimulus file");
		end
		limit = nvec * 20 + 2000;
		repeat (5) @(posedge clk);
		#1;
		check_value("outbubble", 32'(outbubble), 32'd1);	// reset state
		check_value("write_reg", 32'(write_reg), 32'd0);
		check_value("outstall", 32'(outstall), 32'd0);
		check_value("outcpsr", outcpsr, 32'd0);
		check_value("write_num", 32'(write_num), 32'd0);
		check_value("write_data", write_data, 32'd0);
		#9;
		rst = 1'b0;
		@(posedge clk);
		#1;
		for (int v = 0; v < nvec; v++)
			run_vector(v);
		run_multiply(mult_insn(1'b1, 4'h3, 4'h1, 4'h2), 32'h0, 32'h0, 32'h5, 32'h1234);
		run_multiply(mult_insn(1'b0, 4'hc, 4'h4, 4'h5), 32'h8000_0000, 32'hffff_ffff,
			32'hffff_ffff, 32'h7);
		multiply_under_stall(mult_insn(1'b1, 4'h9, 4'h0, 4'h1), 32'h35, 32'h101,
			32'h10);
		for (int k = 0; k < rand_mults; k++) begin
			r = $urandom;
			run_multiply(mult_insn(r[0], r[7:4], r[11:8], r[15:12]), $urandom & 32'hf000_0000,
				$urandom, $urandom, $urandom);
		end
		$display("** PASS **");
		$finish;
	end

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
	output logic clk
);

	localparam int half_period = 50;	// 100 ns period

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

endmodule
